// ==== u2_core_pkg.sv ====
`default_nettype none

package u2_core_pkg;

   ////////////////////////////////////////////////////////////
   // Settings bus

   // Register address on the settings bus
   typedef logic [7:0] set_addr_t;

   // Settings data word
   typedef logic [31:0] set_data_t;

   // One settings write, valid only in the cycle where stb is high
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   ////////////////////////////////////////////////////////////
   // Time base and readback

   // VITA time, full seconds and ticks in one counter
   typedef logic [63:0] vita_time_t;

   // Word returned on a host read
   typedef logic [31:0] rb_word_t;

   ////////////////////////////////////////////////////////////
   // Register map

   // Misc block uses seven addresses starting here
   localparam int SR_MISC   = 0;
   // Time block uses three addresses starting here
   localparam int SR_TIME64 = 10;

   // Run and clock status LEDs under hardware control after reset
   localparam logic [7:0] LED_SRC_AT_RESET = 8'h1E;

   // Major in the upper half, minor in the lower half
   localparam logic [31:0] COMPAT_NUM = {16'd10, 16'd0};

   ////////////////////////////////////////////////////////////
   // Host bus

   // Byte address width of the AXI4-Lite slave
   localparam int AXIL_ADDR_W = 10;
   // Readback word index width, eight words
   localparam int RB_IDX_W    = 3;

endpackage

`default_nettype wire

// ==== axil_settings_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_settings_bridge
   import u2_core_pkg::*;
#(
   parameter int AXIL_ADDR_W = u2_core_pkg::AXIL_ADDR_W
) (
   input  wire logic                   dsp_clk,
   input  wire logic                   rst_n_i,

   // Write address
   input  wire logic [AXIL_ADDR_W-1:0] awaddr_i,
   input  wire logic                   awvalid_i,
   output logic                        awready_o,

   // Write data
   input  wire set_data_t              wdata_i,
   input  wire logic [3:0]             wstrb_i,
   input  wire logic                   wvalid_i,
   output logic                        wready_o,

   // Write response
   output logic [1:0]                  bresp_o,
   output logic                        bvalid_o,
   input  wire logic                   bready_i,

   // Read address
   input  wire logic [AXIL_ADDR_W-1:0] araddr_i,
   input  wire logic                   arvalid_i,
   output logic                        arready_o,

   // Read data
   output rb_word_t                    rdata_o,
   output logic [1:0]                  rresp_o,
   output logic                        rvalid_o,
   input  wire logic                   rready_i,

   // Readback sources
   input  wire vita_time_t             vita_time_i,
   input  wire vita_time_t             vita_time_pps_i,
   input  wire logic [7:0]             leds_i,
   input  wire logic                   clk_status_i,

   output set_bus_t                    set_bus_o
);

   localparam logic [1:0] RESP_OKAY = 2'b00;

   logic                wr_accept;
   logic                rd_accept;
   logic                bvalid_q;
   logic                rvalid_q;
   logic                set_stb_q;
   set_addr_t           set_addr_q;
   set_data_t           set_data_q;
   logic [RB_IDX_W-1:0] rd_idx;
   rb_word_t            rb_word;
   rb_word_t            rdata_q;

   ////////////////////////////////////////////////////////////
   // Write path

   // Address and data must arrive together, and the last response must be taken.
   // Byte strobes are not supported, every write is a full word (wstrb_i)
   assign wr_accept = awvalid_i & wvalid_i & ~bvalid_q;
   assign awready_o = wr_accept;
   assign wready_o  = wr_accept;

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         set_stb_q <= 1'b0;
         bvalid_q  <= 1'b0;
      end else begin
         set_stb_q <= wr_accept;
         if (wr_accept) begin
            bvalid_q <= 1'b1;
         end else if (bready_i) begin
            bvalid_q <= 1'b0;
         end
      end
   end

   // Word address on the settings bus
   always_ff @(posedge dsp_clk) begin
      if (wr_accept) begin
         set_addr_q <= set_addr_t'(awaddr_i >> 2);
         set_data_q <= wdata_i;
      end
   end

   assign set_bus_o = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};
   assign bvalid_o  = bvalid_q;
   assign bresp_o   = RESP_OKAY;

   ////////////////////////////////////////////////////////////
   // Read path

   assign rd_accept = arvalid_i & ~rvalid_q;
   assign arready_o = rd_accept;
   assign rd_idx    = araddr_i[RB_IDX_W+1:2];

   always_comb begin
      case (rd_idx)
         3'd0:    rb_word = COMPAT_NUM;
         3'd1:    rb_word = vita_time_i[63:32];
         3'd2:    rb_word = vita_time_i[31:0];
         3'd3:    rb_word = vita_time_pps_i[63:32];
         3'd4:    rb_word = vita_time_pps_i[31:0];
         // Status word
         3'd5:    rb_word = {16'd0, leds_i, 7'd0, clk_status_i};
         default: rb_word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else if (rd_accept) begin
         rvalid_q <= 1'b1;
      end else if (rready_i) begin
         rvalid_q <= 1'b0;
      end
   end

   // Sampled at acceptance, held while the host stalls
   always_ff @(posedge dsp_clk) begin
      if (rd_accept) begin
         rdata_q <= rb_word;
      end
   end

   assign rvalid_o = rvalid_q;
   assign rdata_o  = rdata_q;
   assign rresp_o  = RESP_OKAY;

endmodule

`default_nettype wire

// ==== vita_time_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module vita_time_counter
   import u2_core_pkg::*;
#(
   parameter int BASE = SR_TIME64
) (
   input  wire logic     dsp_clk,
   input  wire logic     rst_n_i,
   input  wire set_bus_t set_bus_i,
   input  wire logic     pps_i,
   output vita_time_t    vita_time_o,
   output vita_time_t    vita_time_pps_o
);

   logic        wr_hi;
   logic        wr_lo;
   logic        wr_ctrl;
   set_data_t   pend_hi;
   set_data_t   pend_lo;
   logic        load_now;
   logic        arm_pps;
   logic        armed_q;
   logic [1:0]  pps_sync;
   logic        pps_del;
   logic        pps_edge;
   logic        pps_cap;
   vita_time_t  time_q;
   vita_time_t  time_pps_q;

   ////////////////////////////////////////////////////////////
   // Settings decode

   assign wr_hi   = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE));
   assign wr_lo   = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE + 1));
   assign wr_ctrl = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE + 2));

   // Bit 0 of the control word picks PPS-aligned load
   assign load_now = wr_ctrl & ~set_bus_i.data[0];
   assign arm_pps  = wr_ctrl & set_bus_i.data[0];

   always_ff @(posedge dsp_clk) begin
      if (wr_hi) begin
         pend_hi <= set_bus_i.data;
      end
      if (wr_lo) begin
         pend_lo <= set_bus_i.data;
      end
   end

   ////////////////////////////////////////////////////////////
   // PPS edge

   // Two flops for metastability, then a registered edge pulse
   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         pps_sync <= 2'b00;
         pps_del  <= 1'b0;
         pps_edge <= 1'b0;
         pps_cap  <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_del  <= pps_sync[1];
         pps_edge <= pps_sync[1] & ~pps_del;
         pps_cap  <= pps_edge;
      end
   end

   ////////////////////////////////////////////////////////////
   // Counter and capture

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         time_q     <= '0;
         time_pps_q <= '0;
         armed_q    <= 1'b0;
      end else begin
         if (load_now) begin
            time_q <= {pend_hi, pend_lo};
         end else if (pps_edge && armed_q) begin
            time_q <= {pend_hi, pend_lo};
         end else begin
            time_q <= time_q + 64'd1;
         end

         if (arm_pps) begin
            armed_q <= 1'b1;
         end else if (pps_edge) begin
            armed_q <= 1'b0;
         end

         // One cycle after the edge, so a PPS load is seen exactly
         if (pps_cap) begin
            time_pps_q <= time_q;
         end
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;

endmodule

`default_nettype wire

// ==== misc_ctrl_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module misc_ctrl_regs
   import u2_core_pkg::*;
#(
   parameter int         BASE             = SR_MISC,
   parameter logic [7:0] LED_SRC_AT_RESET = u2_core_pkg::LED_SRC_AT_RESET
) (
   input  wire logic     dsp_clk,
   input  wire logic     rst_n_i,
   input  wire set_bus_t set_bus_i,
   input  wire logic     run_rx_i,
   input  wire logic     run_tx_i,
   input  wire logic     clk_status_i,
   output logic [3:0]    serdes_ctrl_o,
   output logic [3:0]    adc_ctrl_o,
   output logic          phy_reset_n_o,
   output logic [7:0]    leds_o
);

   logic       wr_serdes;
   logic       wr_adc;
   logic       wr_led_sw;
   logic       wr_phy;
   logic       wr_led_src;
   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic       phy_reset_q;
   logic [7:0] led_sw_q;
   logic [7:0] led_src_q;
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////
   // Register decode

   assign wr_serdes  = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE + 1));
   assign wr_adc     = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE + 2));
   assign wr_led_sw  = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE + 3));
   assign wr_phy     = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE + 4));
   assign wr_led_src = set_bus_i.stb && (set_bus_i.addr == set_addr_t'(BASE + 6));

   always_ff @(posedge dsp_clk) begin
      if (!rst_n_i) begin
         serdes_q    <= 4'd0;
         adc_q       <= 4'd0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= 8'd0;
         led_src_q   <= LED_SRC_AT_RESET;
      end else begin
         if (wr_serdes) begin
            serdes_q <= set_bus_i.data[3:0];
         end
         if (wr_adc) begin
            adc_q <= set_bus_i.data[3:0];
         end
         if (wr_led_sw) begin
            led_sw_q <= set_bus_i.data[7:0];
         end
         if (wr_phy) begin
            phy_reset_q <= set_bus_i.data[0];
         end
         if (wr_led_src) begin
            led_src_q <= set_bus_i.data[7:0];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // LED merge

   // Hardware status LEDs
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, 2'b00};

   // Source bit set picks hardware, clear picks software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign serdes_ctrl_o = serdes_q;
   assign adc_ctrl_o    = adc_q;
   assign phy_reset_n_o = ~phy_reset_q;

endmodule

`default_nettype wire

// ==== u2_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module u2_core
   import u2_core_pkg::*;
(
   input  wire logic                   dsp_clk,
   input  wire logic                   rst_n_i,

   // AXI4-Lite write address
   input  wire logic [AXIL_ADDR_W-1:0] awaddr_i,
   input  wire logic                   awvalid_i,
   output logic                        awready_o,

   // AXI4-Lite write data
   input  wire logic [31:0]            wdata_i,
   input  wire logic [3:0]             wstrb_i,
   input  wire logic                   wvalid_i,
   output logic                        wready_o,

   // AXI4-Lite write response
   output logic [1:0]                  bresp_o,
   output logic                        bvalid_o,
   input  wire logic                   bready_i,

   // AXI4-Lite read address
   input  wire logic [AXIL_ADDR_W-1:0] araddr_i,
   input  wire logic                   arvalid_i,
   output logic                        arready_o,

   // AXI4-Lite read data
   output logic [31:0]                 rdata_o,
   output logic [1:0]                  rresp_o,
   output logic                        rvalid_o,
   input  wire logic                   rready_i,

   // Timing and status
   input  wire logic                   pps_i,
   input  wire logic                   run_rx_i,
   input  wire logic                   run_tx_i,
   input  wire logic                   clk_status_i,

   // Board control
   output logic [7:0]                  leds_o,
   output logic [3:0]                  serdes_ctrl_o,
   output logic [3:0]                  adc_ctrl_o,
   output logic                        phy_reset_n_o
);

   set_bus_t   set_bus;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic [7:0] leds;

   ////////////////////////////////////////////////////////////
   // Host access

   axil_settings_bridge #(
      .AXIL_ADDR_W(AXIL_ADDR_W)
   ) bridge (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
      .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
      .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
      .araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
      .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .leds_i(leds), .clk_status_i(clk_status_i),
      .set_bus_o(set_bus)
   );

   ////////////////////////////////////////////////////////////
   // VITA time

   vita_time_counter #(
      .BASE(SR_TIME64)
   ) time64 (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_bus_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

   ////////////////////////////////////////////////////////////
   // Misc control and LEDs

   misc_ctrl_regs #(
      .BASE(SR_MISC),
      .LED_SRC_AT_RESET(LED_SRC_AT_RESET)
   ) misc (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .set_bus_i(set_bus),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .clk_status_i(clk_status_i),
      .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds)
   );

   assign leds_o = leds;

endmodule

`default_nettype wire

// ==== tb_u2_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_u2_core
   import u2_core_pkg::*;
;

   localparam int          TIMEOUT = 64;
   localparam logic [31:0] SEED    = 32'h155a2e87;

   logic                   dsp_clk;
   logic                   rst_n;
   logic [AXIL_ADDR_W-1:0] awaddr;
   logic                   awvalid;
   logic                   awready_o;
   logic [31:0]            wdata;
   logic [3:0]             wstrb;
   logic                   wvalid;
   logic                   wready_o;
   logic [1:0]             bresp_o;
   logic                   bvalid_o;
   logic                   bready;
   logic [AXIL_ADDR_W-1:0] araddr;
   logic                   arvalid;
   logic                   arready_o;
   logic [31:0]            rdata_o;
   logic [1:0]             rresp_o;
   logic                   rvalid_o;
   logic                   rready;
   logic                   pps;
   logic                   run_rx;
   logic                   run_tx;
   logic                   clk_status;
   logic [7:0]             leds_o;
   logic [3:0]             serdes_ctrl_o;
   logic [3:0]             adc_ctrl_o;
   logic                   phy_reset_n_o;

   // Expected register state
   logic [7:0] m_src;
   logic [7:0] m_sw;
   logic [3:0] m_serdes;
   logic [3:0] m_adc;
   logic       m_phy;
   logic       mon_en;

   int         err_count;
   int         timeout_count;
   int         i;
   int         cnt;
   int         stall;
   logic [31:0] rnd;
   logic [31:0] rnd2;
   rb_word_t   rd;
   rb_word_t   rd_hi;
   rb_word_t   prev;
   vita_time_t t_load;
   vita_time_t t_now;
   vita_time_t t_next;

   u2_core dut (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n),
      .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready_o),
      .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready_o),
      .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready),
      .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready_o),
      .rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready),
      .pps_i(pps), .run_rx_i(run_rx), .run_tx_i(run_tx), .clk_status_i(clk_status),
      .leds_o(leds_o), .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o)
   );

   always #2 dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////////////
   // Reference model

   // Source bit 1 takes the hardware LED, 0 the software LED
   function automatic logic [7:0] ref_leds(input logic [7:0] src, input logic [7:0] sw,
                                           input logic tx, input logic rx, input logic clk_ok);
      logic [7:0] hw;
      logic [7:0] res;
      int         b;
      hw    = 8'd0;
      hw[4] = tx;
      hw[3] = rx;
      hw[2] = clk_ok;
      for (b = 0; b < 8; b++) begin
         res[b] = src[b] ? hw[b] : sw[b];
      end
      return res;
   endfunction

   function automatic rb_word_t ref_status(input logic [7:0] leds, input logic clk_ok);
      rb_word_t w;
      w       = '0;
      w[15:8] = leds;
      w[0]    = clk_ok;
      return w;
   endfunction

   // Misc register map applied to the expected state
   function automatic void update_model(input int unsigned word_addr, input set_data_t data);
      case (word_addr)
         SR_MISC + 1: m_serdes = data[3:0];
         SR_MISC + 2: m_adc    = data[3:0];
         SR_MISC + 3: m_sw     = data[7:0];
         SR_MISC + 4: m_phy    = data[0];
         SR_MISC + 6: m_src    = data[7:0];
         default:     ;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic check_rb_word(input rb_word_t got, input rb_word_t exp, input string what);
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_time(input vita_time_t got, input vita_time_t lo, input vita_time_t hi,
                             input string what);
      if (got < lo || got > hi || $isunknown(got)) begin
         err_count++;
         $display("** Error at %0t: %s is %h, expected %h to %h", $time, what, got, lo, hi);
      end
   endtask

   task automatic check_ctrl(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      timeout_count++;
      $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
   endtask

   // Outputs checked against the model on every falling edge
   always @(negedge dsp_clk) begin
      if (mon_en) begin
         check_ctrl(leds_o, ref_leds(m_src, m_sw, run_tx, run_rx, clk_status), "leds_o");
         check_ctrl({4'd0, serdes_ctrl_o}, {4'd0, m_serdes}, "serdes_ctrl_o");
         check_ctrl({4'd0, adc_ctrl_o}, {4'd0, m_adc}, "adc_ctrl_o");
         check_flag(phy_reset_n_o, ~m_phy, "phy_reset_n_o");
      end
   end

   ////////////////////////////////////////////////////////////
   // AXI4-Lite transactions

   // A stalled response keeps a second write offered to prove it is held off
   task automatic axi_write(input int unsigned word_addr, input set_data_t data, input int n_stall);
      int   k;
      logic seen;
      awaddr  = AXIL_ADDR_W'(word_addr * 4);
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      k       = 0;
      seen    = 1'b0;
      while (!seen && k < TIMEOUT) begin
         @(negedge dsp_clk);
         if (awready_o && wready_o) seen = 1'b1;
         else k++;
      end
      @(posedge dsp_clk);
      #1;
      if (!seen) begin
         report_timeout("write handshake");
         awvalid = 1'b0;
         wvalid  = 1'b0;
         return;
      end
      awvalid = (n_stall > 0);
      wvalid  = (n_stall > 0);
      bready  = (n_stall == 0);
      k       = 0;
      seen    = 1'b0;
      while (!seen && k < TIMEOUT) begin
         @(negedge dsp_clk);
         if (bvalid_o) seen = 1'b1;
         else k++;
      end
      if (!seen) begin
         report_timeout("write response");
      end
      check_ctrl({6'd0, bresp_o}, 8'd0, "bresp_o");
      // Strobe in this cycle, register output after the next edge
      @(posedge dsp_clk);
      #1;
      update_model(word_addr, data);
      if (n_stall > 0) begin
         for (k = 0; k < n_stall; k++) begin
            check_flag(awready_o, 1'b0, "awready_o with response pending");
            check_flag(wready_o, 1'b0, "wready_o with response pending");
            check_flag(bvalid_o, 1'b1, "bvalid_o under back-pressure");
            @(negedge dsp_clk);
         end
         @(posedge dsp_clk);
         #1;
         awvalid = 1'b0;
         wvalid  = 1'b0;
         bready  = 1'b1;
         @(posedge dsp_clk);
         #1;
      end
      bready = 1'b0;
   endtask

   task automatic axi_read(input int unsigned idx, input int n_stall, output rb_word_t data);
      int   k;
      logic seen;
      data    = '0;
      araddr  = AXIL_ADDR_W'(idx * 4);
      arvalid = 1'b1;
      k       = 0;
      seen    = 1'b0;
      while (!seen && k < TIMEOUT) begin
         @(negedge dsp_clk);
         if (arready_o) seen = 1'b1;
         else k++;
      end
      @(posedge dsp_clk);
      #1;
      if (!seen) begin
         arvalid = 1'b0;
         report_timeout("read address handshake");
         return;
      end
      // A stalled read keeps the address offered to prove it is held off
      arvalid = (n_stall > 0);
      rready  = (n_stall == 0);
      k       = 0;
      seen    = 1'b0;
      while (!seen && k < TIMEOUT) begin
         @(negedge dsp_clk);
         if (rvalid_o) seen = 1'b1;
         else k++;
      end
      if (!seen) begin
         report_timeout("read data");
      end
      data = rdata_o;
      check_ctrl({6'd0, rresp_o}, 8'd0, "rresp_o");
      if (n_stall > 0) begin
         for (k = 0; k < n_stall; k++) begin
            check_flag(arready_o, 1'b0, "arready_o with read data pending");
            check_flag(rvalid_o, 1'b1, "rvalid_o under back-pressure");
            check_rb_word(rdata_o, data, "rdata_o under back-pressure");
            @(negedge dsp_clk);
         end
         @(posedge dsp_clk);
         #1;
         arvalid = 1'b0;
         rready  = 1'b1;
      end
      @(posedge dsp_clk);
      #1;
      rready = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      void'($urandom(SEED));
      dsp_clk = 1'b0;
      rst_n   = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = 4'hF;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      pps     = 1'b0;
      run_rx  = 1'b0;
      run_tx  = 1'b1;
      clk_status = 1'b1;
      m_src    = LED_SRC_AT_RESET;
      m_sw     = 8'd0;
      m_serdes = 4'd0;
      m_adc    = 4'd0;
      m_phy    = 1'b0;
      mon_en   = 1'b0;
      err_count     = 0;
      timeout_count = 0;

      repeat (2) @(posedge dsp_clk);
      #1;
      rst_n  = 1'b1;
      mon_en = 1'b1;

      // Reset values
      axi_read(0, 0, rd);
      check_rb_word(rd, COMPAT_NUM, "compatibility number");
      axi_read(5, 0, rd);
      check_rb_word(rd, ref_status(ref_leds(m_src, m_sw, run_tx, run_rx, clk_status),
                                   clk_status), "status word after reset");
      check_flag(phy_reset_n_o, 1'b1, "phy_reset_n_o after reset");

      // Control registers with random upper data bits
      for (i = 0; i < 6; i++) begin
         rnd = $urandom;
         axi_write(SR_MISC + 1, rnd, 0);
         axi_write(SR_MISC + 2, rnd >> 4, 0);
         axi_write(SR_MISC + 4, rnd >> 8, 0);
      end

      // LED merge
      for (i = 0; i < 8; i++) begin
         rnd  = $urandom;
         rnd2 = $urandom;
         axi_write(SR_MISC + 6, rnd, 0);
         axi_write(SR_MISC + 3, rnd2, 0);
         run_rx     = rnd[16];
         run_tx     = rnd[17];
         clk_status = rnd[18];
         axi_read(5, 0, rd);
         check_rb_word(rd, ref_status(ref_leds(m_src, m_sw, run_tx, run_rx, clk_status),
                                      clk_status), "status word");
      end

      // Immediate time load
      t_load[63:32] = $urandom;
      // Low half clear of a carry between the two reads
      t_load[31:0]  = $urandom & 32'h7FFF_FFFF;
      axi_write(SR_TIME64, t_load[63:32], 0);
      axi_write(SR_TIME64 + 1, t_load[31:0], 0);
      axi_write(SR_TIME64 + 2, 32'd0, 0);
      axi_read(1, 0, rd_hi);
      axi_read(2, 0, rd);
      t_now = {rd_hi, rd};
      check_time(t_now, t_load, t_load + 64'd100, "time after immediate load");
      axi_read(1, 0, rd_hi);
      axi_read(2, 0, rd);
      t_next = {rd_hi, rd};
      check_time(t_next, t_now + 64'd1, t_now + 64'd100, "time on second read");

      // PPS load and capture
      t_load[63:32] = $urandom;
      t_load[31:0]  = $urandom | 32'd1;
      axi_write(SR_TIME64, t_load[63:32], 0);
      axi_write(SR_TIME64 + 1, t_load[31:0], 0);
      axi_write(SR_TIME64 + 2, 32'd1, 0);
      axi_read(4, 0, prev);
      pps = 1'b1;
      repeat (4) @(posedge dsp_clk);
      #1;
      pps = 1'b0;
      cnt = 0;
      rd  = prev;
      while (rd == prev && cnt < TIMEOUT) begin
         axi_read(4, 0, rd);
         cnt++;
      end
      if (rd == prev) begin
         report_timeout("PPS capture update");
      end
      axi_read(3, 0, rd_hi);
      check_time({rd_hi, rd}, t_load, t_load, "PPS capture");

      // Back-pressure on both response channels
      for (i = 0; i < 4; i++) begin
         rnd   = $urandom;
         stall = 1 + int'(rnd[10:8]);
         axi_write(SR_MISC + 1, rnd, stall);
         axi_read(0, stall, rd);
         check_rb_word(rd, COMPAT_NUM, "compatibility number under back-pressure");
         axi_read(5, stall, rd);
         check_rb_word(rd, ref_status(ref_leds(m_src, m_sw, run_tx, run_rx, clk_status),
                                      clk_status), "status word under back-pressure");
      end

      repeat (2) @(posedge dsp_clk);
      mon_en = 1'b0;
      $display("Summary: %0d mismatches, %0d timeouts", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
u2_core_pkg.sv
axil_settings_bridge.sv
vita_time_counter.sv
misc_ctrl_regs.sv
u2_core.sv
tb_u2_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_u2_core
FILELIST  = src.f
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
